/* rtcBus.f */
rtcBusPkg.sv
addressPhase.sv
writePhase.sv
readPhase.sv
transferSequencer.sv
rtcBus.sv
rtcBus_assertions.sv
rtcBusTb.sv

/* rtcBusTb.sv */
module rtcBusTb;

	localparam int transferClocks = 2 * rtcBusPkg::phaseCycles + 1;
	localparam int transferCount = 2 * rtcBusPkg::fieldCount + 6; // last test spans two.
	localparam int timeoutTime = (transferCount * (transferClocks + 4) + 100) * 20;
	localparam int strobeWidth = rtcBusPkg::strobeLast - rtcBusPkg::strobeFirst + 1;

	logic clk;
	logic reset;
	logic initEnable;
	logic sendOne;
	logic writeEnable;
	logic readEnable;
	logic [rtcBusPkg::fieldCount-1:0] fieldSelect;
	logic configFormat;
	logic twelveHour;
	logic [rtcBusPkg::dataWidth-1:0] fieldData;
	logic [rtcBusPkg::dataWidth-1:0] busIn;
	logic [rtcBusPkg::dataWidth-1:0] busOut;
	logic busOutEnable;
	logic [rtcBusPkg::dataWidth-1:0] readData;
	logic cs;
	logic rd;
	logic wr;
	logic ad;

	integer seed = 32'h6ebe;

	// what the chip model saw on the bus.
	logic [rtcBusPkg::dataWidth-1:0] addressSeen;
	logic [rtcBusPkg::dataWidth-1:0] writeSeen;
	logic [rtcBusPkg::dataWidth-1:0] readDriven;
	int adPulses = 0;
	int wrPulses = 0;
	int rdPulses = 0;
	int strobeLowCycles = 0;
	logic prevAd = 1'b1;
	logic prevWr = 1'b1;
	logic prevRd = 1'b1;

	rtcBus DUT (
		.clk(clk),
		.reset(reset),
		.initEnable(initEnable),
		.sendOne(sendOne),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.fieldSelect(fieldSelect),
		.configFormat(configFormat),
		.twelveHour(twelveHour),
		.fieldData(fieldData),
		.busIn(busIn),
		.busOut(busOut),
		.busOutEnable(busOutEnable),
		.readData(readData),
		.cs(cs),
		.rd(rd),
		.wr(wr),
		.ad(ad)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk;
	end

	initial begin
		#(timeoutTime);
		$display("Timeout: the tests did not finish within %0d time units", timeoutTime);
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkByte(input logic [rtcBusPkg::dataWidth-1:0] actual,
		input logic [rtcBusPkg::dataWidth-1:0] expected, input string what);
		if (actual !== expected) begin
			stopRun($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		if (actual != expected) begin
			stopRun($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic checkLevel(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			stopRun($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	// rtc chip model sees rising strobe edges one half cycle late.
	always @(negedge clk) begin
		if (ad && !prevAd) begin
			checkLevel(busOutEnable, 1'b1, "busOutEnable when ad rises");
			checkCount(strobeLowCycles, strobeWidth, "ad low cycles");
			addressSeen = busOut;
			adPulses++;
		end
		if (wr && !prevWr) begin
			checkLevel(busOutEnable, 1'b1, "busOutEnable when wr rises");
			checkCount(strobeLowCycles, strobeWidth, "wr low cycles");
			writeSeen = busOut;
			wrPulses++;
		end
		if (rd && !prevRd) begin
			checkCount(strobeLowCycles, strobeWidth, "rd low cycles");
			rdPulses++;
		end
		if (!ad || !wr || !rd) begin
			strobeLowCycles++;
		end else begin
			strobeLowCycles = 0;
		end
		if (!rd) begin
			if (prevRd) begin
				readDriven = $random(seed); // held for the whole rd pulse.
				busIn = readDriven;
			end
		end else begin
			busIn = $random(seed);
		end
		prevAd = ad;
		prevWr = wr;
		prevRd = rd;
	end

	function automatic logic [rtcBusPkg::dataWidth-1:0] expectedFlagByte(input logic value);
		logic [rtcBusPkg::dataWidth-1:0] result;
		result = '0;
		result[rtcBusPkg::flagBit] = value;
		return result;
	endfunction

	task automatic clearRequests();
		initEnable = 1'b0;
		sendOne = 1'b0;
		writeEnable = 1'b0;
		readEnable = 1'b0;
		fieldSelect = '0;
		configFormat = 1'b0;
		twelveHour = 1'b0;
		fieldData = '0; // the DUT must have latched its copy.
	endtask

	// called on the first falling edge after the sampling edge.
	task automatic waitTransfer();
		int lowCycles;
		lowCycles = 0;
		while (!cs) begin
			lowCycles++;
			if (lowCycles > transferClocks + 2) begin
				stopRun("Transfer did not finish: cs stayed low too long");
			end
			@(negedge clk);
		end
		checkCount(lowCycles, 2 * rtcBusPkg::phaseCycles, "cycles with cs low");
	endtask

	// sends one request pulse and counts the strobes of the transfer it caused.
	task automatic checkTransfer(input int expectWr, input int expectRd);
		int adBefore;
		int wrBefore;
		int rdBefore;
		adBefore = adPulses;
		wrBefore = wrPulses;
		rdBefore = rdPulses;
		@(negedge clk);
		clearRequests();
		waitTransfer();
		checkCount(adPulses - adBefore, 1, "ad pulses");
		checkCount(wrPulses - wrBefore, expectWr, "wr pulses");
		checkCount(rdPulses - rdBefore, expectRd, "rd pulses");
	endtask

	task automatic checkAfterReset();
		checkLevel(cs, 1'b1, "cs after reset");
		checkLevel(rd, 1'b1, "rd after reset");
		checkLevel(wr, 1'b1, "wr after reset");
		checkLevel(ad, 1'b1, "ad after reset");
		checkLevel(busOutEnable, 1'b0, "busOutEnable after reset");
		checkByte(readData, '0, "readData after reset");
	endtask

	task automatic writeField(input int index);
		logic [rtcBusPkg::dataWidth-1:0] data;
		data = $random(seed);
		writeEnable = 1'b1;
		fieldSelect = rtcBusPkg::fieldCount'(1) << index;
		fieldData = data;
		checkTransfer(1, 0);
		checkByte(addressSeen, rtcBusPkg::secondsAddr + 8'(index), "write address");
		checkByte(writeSeen, data, "write data");
	endtask

	// lower fields are also selected so the highest one must win.
	task automatic readField(input int index);
		readEnable = 1'b1;
		fieldSelect = rtcBusPkg::fieldCount'((2 << index) - 1);
		checkTransfer(0, 1);
		checkByte(addressSeen, rtcBusPkg::secondsAddr + 8'(index), "read address");
		checkByte(readData, readDriven, "read data");
	endtask

	task automatic startUp(input logic value);
		initEnable = 1'b1;
		sendOne = value;
		checkTransfer(1, 0);
		checkByte(addressSeen, rtcBusPkg::controlAddr, "start-up address");
		checkByte(writeSeen, expectedFlagByte(value), "start-up data");
	endtask

	task automatic setFormat(input logic value);
		configFormat = 1'b1;
		twelveHour = value;
		checkTransfer(1, 0);
		checkByte(addressSeen, rtcBusPkg::formatAddr, "format address");
		checkByte(writeSeen, expectedFlagByte(value), "format data");
	endtask

	task automatic ignoreBusyRequest();
		int adBefore;
		int wrBefore;
		int rdBefore;
		adBefore = adPulses;
		wrBefore = wrPulses;
		rdBefore = rdPulses;
		writeEnable = 1'b1;
		fieldSelect = rtcBusPkg::fieldCount'(4);
		fieldData = $random(seed);
		@(negedge clk);
		clearRequests();
		repeat (rtcBusPkg::phaseCycles - 1) @(negedge clk);
		readEnable = 1'b1; // halfway through the transfer.
		fieldSelect = rtcBusPkg::fieldCount'(1);
		@(negedge clk);
		clearRequests();
		repeat (transferClocks - rtcBusPkg::phaseCycles) @(negedge clk);
		checkCount(adPulses - adBefore, 1, "ad pulses with a busy request");
		checkCount(wrPulses - wrBefore, 1, "wr pulses with a busy request");
		checkCount(rdPulses - rdBefore, 0, "rd pulses with a busy request");
		repeat (transferClocks) begin
			checkLevel(cs, 1'b1, "cs after the ignored request");
			@(negedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		busIn = '0;
		clearRequests();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		checkAfterReset();
		@(negedge clk);
		for (int i = 0; i < rtcBusPkg::fieldCount; i++) begin
			writeField(i);
		end
		for (int i = 0; i < rtcBusPkg::fieldCount; i++) begin
			readField(i);
		end
		startUp(1'b1);
		startUp(1'b0);
		setFormat(1'b1);
		setFormat(1'b0);
		ignoreBusyRequest();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* rtcBus_assertions.sv */
module rtcBusAssertions (
	input logic clk,
	input logic reset,
	input logic cs,
	input logic rd,
	input logic wr,
	input logic ad,
	input logic busOutEnable
);

	// the chip decodes one strobe at a time.
	oneStrobeLow: assert property (@(posedge clk) disable iff (reset)
		$onehot0({!rd, !wr, !ad}))
		else $error("more than one of rd, wr and ad is low");

	strobeInsideCs: assert property (@(posedge clk) disable iff (reset)
		(!rd || !wr || !ad) |-> !cs)
		else $error("a strobe is low while cs is high");

	// chip drives the lane while rd is low.
	laneReleasedOnRead: assert property (@(posedge clk) disable iff (reset)
		!rd |-> !busOutEnable)
		else $error("busOutEnable is high while rd is low");

endmodule

bind rtcBus rtcBusAssertions strobeRules (
	.clk(clk),
	.reset(reset),
	.cs(cs),
	.rd(rd),
	.wr(wr),
	.ad(ad),
	.busOutEnable(busOutEnable)
);

/* rtcBus.sv */
module rtcBus (
	input logic clk,
	input logic reset,
	input logic initEnable,
	input logic sendOne,
	input logic writeEnable,
	input logic readEnable,
	input logic [rtcBusPkg::fieldCount-1:0] fieldSelect,
	input logic configFormat,
	input logic twelveHour,
	input logic [rtcBusPkg::dataWidth-1:0] fieldData,
	input logic [rtcBusPkg::dataWidth-1:0] busIn,
	output logic [rtcBusPkg::dataWidth-1:0] busOut,
	output logic busOutEnable,
	output logic [rtcBusPkg::dataWidth-1:0] readData,
	output logic cs,
	output logic rd,
	output logic wr,
	output logic ad
);

	logic [rtcBusPkg::dataWidth-1:0] address;
	logic [rtcBusPkg::dataWidth-1:0] writeData;
	logic [rtcBusPkg::dataWidth-1:0] addressBus;
	logic [rtcBusPkg::dataWidth-1:0] writeBus;
	logic addressRun;
	logic writeRun;
	logic readRun;
	logic addressDone;
	logic writeDone;
	logic readDone;
	logic addressCs;
	logic addressAd;
	logic writeCs;
	logic writeWr;
	logic readCs;
	logic readRd;

	transferSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.initEnable(initEnable),
		.sendOne(sendOne),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.fieldSelect(fieldSelect),
		.configFormat(configFormat),
		.twelveHour(twelveHour),
		.fieldData(fieldData),
		.addressDone(addressDone),
		.writeDone(writeDone),
		.readDone(readDone),
		.addressCs(addressCs),
		.addressAd(addressAd),
		.writeCs(writeCs),
		.writeWr(writeWr),
		.readCs(readCs),
		.readRd(readRd),
		.addressBus(addressBus),
		.writeBus(writeBus),
		.address(address),
		.writeData(writeData),
		.addressRun(addressRun),
		.writeRun(writeRun),
		.readRun(readRun),
		.busOut(busOut),
		.busOutEnable(busOutEnable),
		.cs(cs),
		.rd(rd),
		.wr(wr),
		.ad(ad)
	);

	addressPhase addressCycle (
		.clk(clk),
		.reset(reset),
		.run(addressRun),
		.address(address),
		.busOut(addressBus),
		.cs(addressCs),
		.ad(addressAd),
		.done(addressDone)
	);

	writePhase writeCycle (
		.clk(clk),
		.reset(reset),
		.run(writeRun),
		.writeData(writeData),
		.busOut(writeBus),
		.cs(writeCs),
		.wr(writeWr),
		.done(writeDone)
	);

	readPhase readCycle (
		.clk(clk),
		.reset(reset),
		.run(readRun),
		.busIn(busIn),
		.readData(readData),
		.cs(readCs),
		.rd(readRd),
		.done(readDone)
	);

endmodule

/* transferSequencer.sv */
module transferSequencer (
	input logic clk,
	input logic reset,
	input logic initEnable,
	input logic sendOne,
	input logic writeEnable,
	input logic readEnable,
	input logic [rtcBusPkg::fieldCount-1:0] fieldSelect,
	input logic configFormat,
	input logic twelveHour,
	input logic [rtcBusPkg::dataWidth-1:0] fieldData,
	input logic addressDone,
	input logic writeDone,
	input logic readDone,
	input logic addressCs,
	input logic addressAd,
	input logic writeCs,
	input logic writeWr,
	input logic readCs,
	input logic readRd,
	input logic [rtcBusPkg::dataWidth-1:0] addressBus,
	input logic [rtcBusPkg::dataWidth-1:0] writeBus,
	output logic [rtcBusPkg::dataWidth-1:0] address,
	output logic [rtcBusPkg::dataWidth-1:0] writeData,
	output logic addressRun,
	output logic writeRun,
	output logic readRun,
	output logic [rtcBusPkg::dataWidth-1:0] busOut,
	output logic busOutEnable,
	output logic cs,
	output logic rd,
	output logic wr,
	output logic ad
);

	logic [rtcBusPkg::stateWidth-1:0] state;
	logic isRead;
	logic fieldAny;
	logic [rtcBusPkg::dataWidth-1:0] fieldAddress;
	logic [rtcBusPkg::dataWidth-1:0] flagByte;
	logic requestValid;
	logic requestRead;
	logic [rtcBusPkg::dataWidth-1:0] requestAddress;
	logic [rtcBusPkg::dataWidth-1:0] requestData;
	logic dataDone;

	// highest selected field wins.
	always_comb begin
		fieldAny = |fieldSelect;
		fieldAddress = rtcBusPkg::secondsAddr;
		for (int i = 0; i < rtcBusPkg::fieldCount; i++) begin
			if (fieldSelect[i]) begin
				fieldAddress = rtcBusPkg::secondsAddr + rtcBusPkg::dataWidth'(i);
			end
		end
	end

	// request decode, format first, then read, write, init.
	always_comb begin
		flagByte = '0;
		flagByte[rtcBusPkg::flagBit] = configFormat ? twelveHour : sendOne;
		requestValid = 1'b1;
		requestRead = 1'b0;
		requestAddress = rtcBusPkg::controlAddr;
		requestData = flagByte;
		if (configFormat) begin
			requestAddress = rtcBusPkg::formatAddr;
		end else if (readEnable && fieldAny) begin
			requestRead = 1'b1;
			requestAddress = fieldAddress;
		end else if (writeEnable && fieldAny) begin
			requestAddress = fieldAddress;
			requestData = fieldData;
		end else if (!initEnable) begin
			requestValid = 1'b0;
		end
	end

	assign dataDone = isRead ? readDone : writeDone;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rtcBusPkg::idleState;
			isRead <= 1'b0;
		end else begin
			case (state)
				rtcBusPkg::idleState: begin
					if (requestValid) begin
						state <= rtcBusPkg::addressState;
						isRead <= requestRead;
					end
				end
				rtcBusPkg::addressState: begin
					if (addressDone) begin
						state <= rtcBusPkg::dataState; // data phase follows back to back.
					end
				end
				rtcBusPkg::dataState: begin
					if (dataDone) begin
						state <= rtcBusPkg::idleState;
					end
				end
				default: begin
					state <= rtcBusPkg::idleState;
				end
			endcase
		end
	end

	// transfer payload, captured with the request.
	always_ff @(posedge clk) begin
		if (state == rtcBusPkg::idleState && requestValid) begin
			address <= requestAddress;
			writeData <= requestData;
		end
	end

	assign addressRun = state == rtcBusPkg::addressState;
	assign writeRun = state == rtcBusPkg::dataState && !isRead;
	assign readRun = state == rtcBusPkg::dataState && isRead;

	// only one phase runs, so the idle-high strobes simply AND together.
	assign cs = addressCs & writeCs & readCs;
	assign ad = addressAd;
	assign wr = writeWr;
	assign rd = readRd;

	assign busOut = addressRun ? addressBus : (writeRun ? writeBus : '0);
	assign busOutEnable = addressRun || writeRun; // lane released for reads.

endmodule

/* readPhase.sv */
module readPhase (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [rtcBusPkg::dataWidth-1:0] busIn,
	output logic [rtcBusPkg::dataWidth-1:0] readData,
	output logic cs,
	output logic rd,
	output logic done
);

	logic [rtcBusPkg::phaseCountWidth-1:0] count;
	logic inWindow;
	logic captureNow;

	always_ff @(posedge clk) begin
		if (reset || !run) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_comb begin
		inWindow = run
			&& count >= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeFirst)
			&& count <= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeLast);
		captureNow = run
			&& count == rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeLast);
	end

	// sample at the last low cycle of rd, when the chip output has settled.
	always_ff @(posedge clk) begin
		if (reset) begin
			readData <= '0;
		end else if (captureNow) begin
			readData <= busIn; // held until the next read.
		end
	end

	assign cs = !run;
	assign rd = !inWindow;
	assign done = run
		&& count == rtcBusPkg::phaseCountWidth'(rtcBusPkg::phaseCycles - 1);

endmodule

/* writePhase.sv */
module writePhase (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [rtcBusPkg::dataWidth-1:0] writeData,
	output logic [rtcBusPkg::dataWidth-1:0] busOut,
	output logic cs,
	output logic wr,
	output logic done
);

	logic [rtcBusPkg::phaseCountWidth-1:0] count;
	logic inWindow;
	logic lastCount;

	always_ff @(posedge clk) begin
		if (reset || !run) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_comb begin
		inWindow = run
			&& count >= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeFirst)
			&& count <= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeLast);
		lastCount = count == rtcBusPkg::phaseCountWidth'(rtcBusPkg::phaseCycles - 1);
	end

	// data held for the whole phase, so it is stable around both wr edges.
	assign busOut = run ? writeData : '0;
	assign cs = !run;
	assign wr = !inWindow; // rtc latches on the rising edge.
	assign done = run && lastCount;

endmodule

/* addressPhase.sv */
module addressPhase (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [rtcBusPkg::dataWidth-1:0] address,
	output logic [rtcBusPkg::dataWidth-1:0] busOut,
	output logic cs,
	output logic ad,
	output logic done
);

	logic [rtcBusPkg::phaseCountWidth-1:0] count;
	logic inWindow;

	always_ff @(posedge clk) begin
		if (reset || !run) begin
			count <= '0;
		end else begin
			count <= count + 1'b1; // wraps back to zero at the end.
		end
	end

	always_comb begin
		inWindow = run
			&& count >= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeFirst)
			&& count <= rtcBusPkg::phaseCountWidth'(rtcBusPkg::strobeLast);
	end

	// chip latches the address on the rising edge of ad.
	assign cs = !run;
	assign ad = !inWindow;
	assign busOut = run ? address : '0;
	assign done = run
		&& count == rtcBusPkg::phaseCountWidth'(rtcBusPkg::phaseCycles - 1);

endmodule

/* rtcBusPkg.sv */
package rtcBusPkg;

	// bus lane.
	localparam int dataWidth = 8;

	// every phase is the same length.
	localparam int phaseCycles = 8;
	localparam int phaseCountWidth = 3;

	// strobe low window inside a phase.
	localparam int strobeFirst = 2;
	localparam int strobeLast = 5;

	// rtc register map.
	localparam logic [dataWidth-1:0] controlAddr = 8'h02;
	localparam logic [dataWidth-1:0] formatAddr = 8'h00;
	localparam logic [dataWidth-1:0] secondsAddr = 8'h21; // minutes to year follow.

	// bit written for start-up and 12/24 format.
	localparam int flagBit = 4;

	// seconds, minutes, hours, day, month, year.
	localparam int fieldCount = 6;

	// sequencer FSM encoding.
	localparam int stateWidth = 2;
	localparam logic [stateWidth-1:0] idleState = 2'd0;
	localparam logic [stateWidth-1:0] addressState = 2'd1;
	localparam logic [stateWidth-1:0] dataState = 2'd2;

endpackage
